// File: rtl/dis_pkg.sv
/*
 * Widths, bit positions and record types shared by the dispatch stage.
 * Every file refers to these by scoped name.
 */
package dis_pkg;

    // ------------------------------------------------------------------
    // Widths and plain vector types
    // ------------------------------------------------------------------
    localparam int unsigned XLEN = 32;          // Data width

    typedef logic [XLEN-1:0] xlen_t;            // Data word
    typedef logic [4:0]      reg_addr_t;        // GPR address
    typedef logic [4:0]      uop_t;             // Micro-op
    typedef logic [4:0]      fu_t;              // One-hot functional unit
    typedef logic [1:0]      size_t;            // [0] 16-bit, [1] 32-bit
    typedef logic [7:0]      opr_src_t;         // One-hot operand sources

    localparam xlen_t PC_RESET = 32'h8000_0000; // PC value out of reset

    // ------------------------------------------------------------------
    // Bit positions
    // ------------------------------------------------------------------
    localparam int unsigned FU_ALU = 0;         // Within fu_t
    localparam int unsigned FU_MUL = 1;
    localparam int unsigned FU_LSU = 2;
    localparam int unsigned FU_CFU = 3;
    localparam int unsigned FU_CSR = 4;

    localparam int unsigned LSU_STORE = 4;      // Uop bit marking a store

    localparam int unsigned OPRA_RS1  = 0;      // Operand A sources
    localparam int unsigned OPRA_PCIM = 1;
    localparam int unsigned OPRA_CSRI = 2;
    localparam int unsigned OPRB_RS2  = 3;      // Operand B sources
    localparam int unsigned OPRB_IMM  = 4;
    localparam int unsigned OPRC_RS2  = 5;      // Operand C sources
    localparam int unsigned OPRC_CSRA = 6;
    localparam int unsigned OPRC_PCIM = 7;

    // ------------------------------------------------------------------
    // Records
    // ------------------------------------------------------------------
    typedef struct packed {
        reg_addr_t rd;                          // Destination register
        reg_addr_t rs1;                         // Source register 1
        reg_addr_t rs2;                         // Source register 2
        xlen_t     imm;                         // Decoded immediate
        uop_t      uop;                         // Micro-op
        fu_t       fu;                          // Functional unit
        logic      trap;                        // Raise a trap
        opr_src_t  opr_src;                     // Operand source flags
        size_t     size;                        // Instruction size
        xlen_t     instr;                       // Instruction word
    } s2_instr_t;

    typedef struct packed {
        reg_addr_t rd;                          // Stage destination
        xlen_t     wdata;                       // Result to forward
        logic      load;                        // Stage holds a load
        logic      csr;                         // Stage holds a CSR op
    } fwd_src_t;

    typedef struct packed {
        logic      wen;                         // Write enable
        reg_addr_t rd;                          // Write address
        xlen_t     wdata;                       // Write data
    } gpr_wr_t;

    typedef struct packed {
        reg_addr_t rd;
        xlen_t     pc;
        uop_t      uop;
        fu_t       fu;
        size_t     size;
        xlen_t     instr;
        xlen_t     opr_a;
        xlen_t     opr_b;
        xlen_t     opr_c;
        logic      trap;
    } s3_op_t;

endpackage

// File: rtl/dis_gprs.sv
/*
 * General purpose register file, 31 writable registers, x0 hardwired to
 * zero. Two combinational read ports and one synchronous write port.
 */
module dis_gprs (
    input  logic               g_clk,    // Global clock
    input  logic               g_resetn, // Sync reset, active low
    input  dis_pkg::reg_addr_t rs1_addr, // Read port 1 address
    output dis_pkg::xlen_t     rs1_data, // Read port 1 data
    input  dis_pkg::reg_addr_t rs2_addr, // Read port 2 address
    output dis_pkg::xlen_t     rs2_data, // Read port 2 data
    input  dis_pkg::gpr_wr_t   wr        // Write port
);

    dis_pkg::xlen_t regs [1:31];         // No storage behind x0

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;           // All registers start at zero
            end
        end else if (wr.wen && (wr.rd != 5'd0)) begin
            regs[wr.rd] <= wr.wdata;     // Writes to x0 dropped
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr]; // x0 reads zero
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    // Writeback must never present an unknown address with a live enable
    wr_addr_known: assert property (@(posedge g_clk) disable iff (!g_resetn)
        wr.wen |-> !$isunknown(wr.rd));

endmodule

// File: rtl/dis_operand_fwd.sv
/*
 * Resolves rs1/rs2 values with forwarding from stages 3 and 4 ahead of the
 * register file, and raises a bubble on hazards forwarding cannot cover.
 */
module dis_operand_fwd (
    input  logic               g_clk,     // Global clock
    input  logic               g_resetn,  // Sync reset, active low
    input  dis_pkg::reg_addr_t rs1,       // Source register 1
    input  dis_pkg::reg_addr_t rs2,       // Source register 2
    input  dis_pkg::fwd_src_t  fwd_s3,    // Execute stage result
    input  dis_pkg::fwd_src_t  fwd_s4,    // Writeback stage result
    input  dis_pkg::gpr_wr_t   gpr_wr,    // Register file write
    input  logic               pipe_busy, // Pipe register stalled
    output dis_pkg::xlen_t     rs1_val,   // Resolved rs1
    output dis_pkg::xlen_t     rs2_val,   // Resolved rs2
    output logic               bubble,    // Unresolvable RAW hazard
    output logic               busy       // Stage cannot accept
);

    dis_pkg::xlen_t rs1_rf;               // Raw register file data
    dis_pkg::xlen_t rs2_rf;
    logic           s3_rs1;               // Forward hits, x0 excluded
    logic           s4_rs1;
    logic           s3_rs2;
    logic           s4_rs2;
    logic           s3_hit;               // Either source matches stage rd
    logic           s4_hit;

    dis_gprs i_gprs (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .rs1_addr (rs1),
        .rs1_data (rs1_rf),
        .rs2_addr (rs2),
        .rs2_data (rs2_rf),
        .wr       (gpr_wr)
    );

    // ------------------------------------------------------------------
    // Forwarding select, newest result wins
    // ------------------------------------------------------------------
    assign s3_rs1 = (rs1 == fwd_s3.rd) && (rs1 != 5'd0);
    assign s4_rs1 = (rs1 == fwd_s4.rd) && (rs1 != 5'd0);
    assign s3_rs2 = (rs2 == fwd_s3.rd) && (rs2 != 5'd0);
    assign s4_rs2 = (rs2 == fwd_s4.rd) && (rs2 != 5'd0);

    assign rs1_val = s3_rs1 ? fwd_s3.wdata :
                     s4_rs1 ? fwd_s4.wdata : rs1_rf;
    assign rs2_val = s3_rs2 ? fwd_s3.wdata :
                     s4_rs2 ? fwd_s4.wdata : rs2_rf;

    // ------------------------------------------------------------------
    // Hazard bubble
    // ------------------------------------------------------------------
    assign s3_hit = (rs1 == fwd_s3.rd) || (rs2 == fwd_s3.rd);
    assign s4_hit = (rs1 == fwd_s4.rd) || (rs2 == fwd_s4.rd);

    assign bubble = ((fwd_s3.load || fwd_s3.csr) && s3_hit) || // Result not ready yet
                    (fwd_s4.csr && s4_hit);                    // CSR read late
    assign busy   = bubble || pipe_busy;

endmodule

// File: rtl/dis_pc_track.sv
/*
 * Program counter aligned to the decode stage. Follows redirects, steps by
 * instruction size on each transfer and supplies PC plus immediate.
 */
module dis_pc_track (
    input  logic            g_clk,     // Global clock
    input  logic            g_resetn,  // Sync reset, active low
    input  logic            advance,   // Instruction transferred in
    input  dis_pkg::size_t  size,      // Size of that instruction
    input  logic            cf_req,    // Redirect request
    input  logic            cf_ack,    // Redirect acknowledge
    input  dis_pkg::xlen_t  cf_target, // Redirect destination
    input  dis_pkg::xlen_t  imm,       // Decoded immediate
    output dis_pkg::xlen_t  pc,        // Current PC
    output dis_pkg::xlen_t  pc_imm     // PC + immediate
);

    dis_pkg::xlen_t pc_next;           // Sequential successor

    assign pc_next = pc + {29'b0, size[1], size[0], 1'b0}; // +2 or +4

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= dis_pkg::PC_RESET;
        end else if (cf_req && cf_ack) begin
            pc <= cf_target;           // Redirect beats sequential step
        end else if (advance) begin
            pc <= pc_next;
        end
    end

    assign pc_imm = pc + imm;          // Branch and AUIPC targets

    // Redirect targets and size steps must keep half-word alignment
    pc_aligned: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !pc[0]);

endmodule

// File: rtl/dis_operand_mux.sv
/*
 * Builds the next stage-3 record from the decoded instruction, resolved
 * register values and PC values. Purely combinational.
 */
module dis_operand_mux (
    input  dis_pkg::s2_instr_t ins,     // Decoded instruction
    input  dis_pkg::xlen_t     rs1_val, // Resolved rs1
    input  dis_pkg::xlen_t     rs2_val, // Resolved rs2
    input  dis_pkg::xlen_t     pc,      // Decode-aligned PC
    input  dis_pkg::xlen_t     pc_imm,  // PC + immediate
    output dis_pkg::s3_op_t    next_op  // Record for stage 3
);

    dis_pkg::xlen_t csr_imm;            // rs1 field as CSR immediate
    dis_pkg::xlen_t csr_addr;           // CSR address from imm[31:20]
    logic           cfu_cond;           // Conditional branch
    logic           no_rd;              // No writeback expected

    assign csr_imm  = {27'b0, ins.rs1};
    assign csr_addr = {20'b0, ins.imm[31:20]};

    assign cfu_cond = ins.fu[dis_pkg::FU_CFU] && (ins.uop[4:3] == 2'b00);

    // Trap keeps rd since it carries the cause code
    assign no_rd = ((ins.fu[dis_pkg::FU_LSU] && ins.uop[dis_pkg::LSU_STORE]) ||
                    cfu_cond) && !ins.trap;

    always_comb begin
        next_op.rd    = no_rd ? 5'd0 : ins.rd; // Keeps forwarding clean
        next_op.pc    = pc;
        next_op.uop   = ins.uop;
        next_op.fu    = ins.fu;
        next_op.size  = ins.size;
        next_op.instr = ins.instr;
        next_op.trap  = ins.trap;

        // Operand A
        next_op.opr_a = ({dis_pkg::XLEN{ins.opr_src[dis_pkg::OPRA_RS1]}}  & rs1_val) |
                        ({dis_pkg::XLEN{ins.opr_src[dis_pkg::OPRA_PCIM]}} & pc_imm)  |
                        ({dis_pkg::XLEN{ins.opr_src[dis_pkg::OPRA_CSRI]}} & csr_imm);

        // Operand B
        next_op.opr_b = ({dis_pkg::XLEN{ins.opr_src[dis_pkg::OPRB_RS2]}} & rs2_val) |
                        ({dis_pkg::XLEN{ins.opr_src[dis_pkg::OPRB_IMM]}} & ins.imm);

        // Operand C
        next_op.opr_c = ({dis_pkg::XLEN{ins.opr_src[dis_pkg::OPRC_RS2]}}  & rs2_val)  |
                        ({dis_pkg::XLEN{ins.opr_src[dis_pkg::OPRC_CSRA]}} & csr_addr) |
                        ({dis_pkg::XLEN{ins.opr_src[dis_pkg::OPRC_PCIM]}} & pc_imm);
    end

endmodule

// File: rtl/dis_pipe_reg.sv
/*
 * Stage 2 to stage 3 pipeline register with valid/busy handshake.
 * A bubble loads an empty slot; flush drops whatever is held.
 */
module dis_pipe_reg (
    input  logic             g_clk,     // Global clock
    input  logic             g_resetn,  // Sync reset, active low
    input  logic             in_valid,  // Upstream has an instruction
    input  dis_pkg::s3_op_t  in_data,   // Record to load
    input  logic             in_bubble, // Hazard, load empty slot
    input  logic             flush,     // Drop held record
    output logic             busy,      // Cannot load this cycle
    output logic             out_valid, // Record valid for stage 3
    output dis_pkg::s3_op_t  out_data,  // Held record
    input  logic             out_busy   // Stage 3 stalled
);

    logic load;                         // Real instruction captured

    assign busy = out_valid && out_busy; // Full and downstream stalled
    assign load = !busy && in_valid && !in_bubble;

    // ------------------------------------------------------------------
    // Valid flag
    // ------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!busy) begin
            out_valid <= load;          // Bubble leaves an empty slot
        end
    end

    // ------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (load && !flush) begin
            out_data <= in_data;
        end
    end

    // Stage 3 must see a frozen record for as long as it stalls
    out_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (out_valid && out_busy) |=> $stable(out_data));

endmodule

// File: rtl/dis_stage.sv
/*
 * Dispatch stage top level. Connects forwarding, PC tracking, operand
 * assembly and the stage-3 pipe register.
 */
module dis_stage (
    input  logic                g_clk,     // Global clock
    input  logic                g_resetn,  // Sync reset, active low
    input  logic                s2_valid,  // Decode has an instruction
    output logic                s2_busy,   // Stage cannot accept
    input  dis_pkg::s2_instr_t  s2_in,     // Decoded instruction
    input  logic                flush,     // Flush stage
    input  logic                cf_req,    // Redirect request
    input  logic                cf_ack,    // Redirect acknowledge
    input  dis_pkg::xlen_t      cf_target, // Redirect destination
    input  dis_pkg::fwd_src_t   fwd_s3,    // Execute stage forward
    input  dis_pkg::fwd_src_t   fwd_s4,    // Writeback stage forward
    input  dis_pkg::gpr_wr_t    gpr_wr,    // Register file write
    input  logic                s3_busy,   // Execute stalled
    output logic                s3_valid,  // Record valid
    output dis_pkg::s3_op_t     s3_out     // Record for execute
);

    dis_pkg::xlen_t  rs1_val;              // Forwarded operands
    dis_pkg::xlen_t  rs2_val;
    logic            bubble;               // RAW hazard this cycle
    logic            pipe_busy;            // Pipe register stalled
    dis_pkg::xlen_t  pc;
    dis_pkg::xlen_t  pc_imm;
    dis_pkg::s3_op_t next_op;              // Assembled record
    logic            advance;              // Instruction accepted

    assign advance = s2_valid && !s2_busy;

    dis_operand_fwd i_operand_fwd (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .rs1       (s2_in.rs1),
        .rs2       (s2_in.rs2),
        .fwd_s3    (fwd_s3),
        .fwd_s4    (fwd_s4),
        .gpr_wr    (gpr_wr),
        .pipe_busy (pipe_busy),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .bubble    (bubble),
        .busy      (s2_busy)
    );

    dis_pc_track i_pc_track (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .advance   (advance),
        .size      (s2_in.size),
        .cf_req    (cf_req),
        .cf_ack    (cf_ack),
        .cf_target (cf_target),
        .imm       (s2_in.imm),
        .pc        (pc),
        .pc_imm    (pc_imm)
    );

    dis_operand_mux i_operand_mux (
        .ins     (s2_in),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .pc      (pc),
        .pc_imm  (pc_imm),
        .next_op (next_op)
    );

    dis_pipe_reg i_pipe_reg (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .in_valid  (s2_valid),
        .in_data   (next_op),
        .in_bubble (bubble),
        .flush     (flush),
        .busy      (pipe_busy),
        .out_valid (s3_valid),
        .out_data  (s3_out),
        .out_busy  (s3_busy)
    );

endmodule

// File: bench/tb_dis_model.svh
/*
 * Reference model for the dispatch stage testbench. Included inside the
 * testbench module; keeps a shadow register file and PC.
 */
`ifndef TB_DIS_MODEL_SVH
`define TB_DIS_MODEL_SVH

    dis_pkg::xlen_t shadow_regs [0:31];                 // Entry 0 stays zero
    dis_pkg::xlen_t shadow_pc;                          // Decode-aligned PC

    // ------------------------------------------------------------------
    // Source value and hazard prediction
    // ------------------------------------------------------------------
    function automatic dis_pkg::xlen_t forward_value(input dis_pkg::reg_addr_t a,
                                                     input dis_pkg::fwd_src_t f3,
                                                     input dis_pkg::fwd_src_t f4);
        if (a == 5'd0) return '0;                       // x0 never forwarded
        if (a == f3.rd) return f3.wdata;                // Newest result first
        if (a == f4.rd) return f4.wdata;
        return shadow_regs[a];
    endfunction

    function automatic logic bubble_expected(input dis_pkg::s2_instr_t ins,
                                             input dis_pkg::fwd_src_t f3,
                                             input dis_pkg::fwd_src_t f4);
        logic hit3;
        logic hit4;
        hit3 = (ins.rs1 == f3.rd) || (ins.rs2 == f3.rd);
        hit4 = (ins.rs1 == f4.rd) || (ins.rs2 == f4.rd);
        return (hit3 && (f3.load || f3.csr)) || (hit4 && f4.csr);
    endfunction

    // ------------------------------------------------------------------
    // Expected stage-3 record
    // ------------------------------------------------------------------
    function automatic dis_pkg::s3_op_t expected_record(input dis_pkg::s2_instr_t ins,
                                                        input dis_pkg::fwd_src_t f3,
                                                        input dis_pkg::fwd_src_t f4);
        dis_pkg::s3_op_t r;
        dis_pkg::xlen_t  v1;
        dis_pkg::xlen_t  v2;
        dis_pkg::xlen_t  pcim;
        logic            store;
        logic            cond;
        v1    = forward_value(ins.rs1, f3, f4);
        v2    = forward_value(ins.rs2, f3, f4);
        pcim  = shadow_pc + ins.imm;
        store = ins.fu[dis_pkg::FU_LSU] && ins.uop[dis_pkg::LSU_STORE];
        cond  = ins.fu[dis_pkg::FU_CFU] && (ins.uop[4:3] == 2'b00);
        r       = '0;
        r.rd    = ((store || cond) && !ins.trap) ? 5'd0 : ins.rd; // No writeback target
        r.pc    = shadow_pc;
        r.uop   = ins.uop;
        r.fu    = ins.fu;
        r.size  = ins.size;
        r.instr = ins.instr;
        r.trap  = ins.trap;
        if (ins.opr_src[dis_pkg::OPRA_RS1])  r.opr_a = r.opr_a | v1;
        if (ins.opr_src[dis_pkg::OPRA_PCIM]) r.opr_a = r.opr_a | pcim;
        if (ins.opr_src[dis_pkg::OPRA_CSRI]) r.opr_a = r.opr_a | {27'd0, ins.rs1};
        if (ins.opr_src[dis_pkg::OPRB_RS2])  r.opr_b = r.opr_b | v2;
        if (ins.opr_src[dis_pkg::OPRB_IMM])  r.opr_b = r.opr_b | ins.imm;
        if (ins.opr_src[dis_pkg::OPRC_RS2])  r.opr_c = r.opr_c | v2;
        if (ins.opr_src[dis_pkg::OPRC_CSRA]) r.opr_c = r.opr_c | {20'd0, ins.imm[31:20]};
        if (ins.opr_src[dis_pkg::OPRC_PCIM]) r.opr_c = r.opr_c | pcim;
        return r;
    endfunction

    // ------------------------------------------------------------------
    // Shadow state updates, applied once per clock
    // ------------------------------------------------------------------
    task automatic update_shadow(input logic accept, input dis_pkg::size_t size,
                                 input logic redirect, input dis_pkg::xlen_t target,
                                 input dis_pkg::gpr_wr_t wr);
        if (redirect) begin
            shadow_pc = target;                         // Redirect wins
        end else if (accept) begin
            shadow_pc = shadow_pc + (size[0] ? 32'd2 : 32'd4);
        end
        if (wr.wen && (wr.rd != 5'd0)) begin
            shadow_regs[wr.rd] = wr.wdata;
        end
    endtask

    task automatic reset_shadow();
        shadow_pc = dis_pkg::PC_RESET;
        for (int i = 0; i < 32; i++) begin
            shadow_regs[i] = '0;
        end
    endtask

`endif

// File: bench/tb_dis_stage.sv
/*
 * Testbench for the dispatch stage. Random and directed dispatches go in
 * and every stage-3 record is checked against the included reference model.
 */
module tb_dis_stage;

    localparam int unsigned CLK_PERIOD = 20;
    localparam int unsigned N_ISSUE    = 80;                   // Dispatches over all tests
    localparam int unsigned REC_W      = $bits(dis_pkg::s3_op_t);
    localparam int unsigned WATCHDOG   = (N_ISSUE * 20 + 200 + 8) * CLK_PERIOD;
    localparam dis_pkg::opr_src_t SRC_REGS =
        dis_pkg::opr_src_t'((1 << dis_pkg::OPRA_RS1) | (1 << dis_pkg::OPRB_RS2));

    logic               g_clk;
    logic               g_resetn;
    logic               s2_valid;
    logic               s2_busy;
    dis_pkg::s2_instr_t s2_in;
    logic               flush;
    logic               cf_req;
    logic               cf_ack;
    dis_pkg::xlen_t     cf_target;
    dis_pkg::fwd_src_t  fwd_s3;
    dis_pkg::fwd_src_t  fwd_s4;
    dis_pkg::gpr_wr_t   gpr_wr;
    logic               s3_busy;
    logic               s3_valid;
    dis_pkg::s3_op_t    s3_out;

    dis_pkg::s3_op_t    expect_q [$];                          // Records still in flight
    dis_pkg::s3_op_t    held_rec;                              // Record seen while stalled
    logic               holding;
    logic               model_valid;                           // Predicted s3_valid
    logic               bp_random;                             // Random stalls enabled
    string              test_name;
    int unsigned        errors;
    int unsigned        compared;

    `include "tb_dis_model.svh"

    dis_stage i_dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired, run did not finish within %0d time units", WATCHDOG);
        $display("Verification failed");
        $finish;
    end

    always @(negedge g_clk) begin
        if (bp_random) begin
            s3_busy = ($urandom_range(3) == 0);                // About one stall in four
        end
    end

    task automatic check_value(input string what, input logic [REC_W-1:0] expected,
                               input logic [REC_W-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", what, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // Compare process running the model in step with the DUT
    // ------------------------------------------------------------------
    always @(posedge g_clk) begin : compare
        logic exp_busy;
        logic accept;
        if (!g_resetn) begin
            reset_shadow();
            model_valid = 1'b0;
            holding     = 1'b0;
        end else begin
            exp_busy = (s2_valid && bubble_expected(s2_in, fwd_s3, fwd_s4)) ||
                       (model_valid && s3_busy);
            accept   = s2_valid && !exp_busy;
            check_value({test_name, " s3_valid"}, REC_W'(model_valid), REC_W'(s3_valid));
            if (s2_valid) begin
                check_value({test_name, " s2_busy"}, REC_W'(exp_busy), REC_W'(s2_busy));
            end
            if (holding) begin
                check_value({test_name, " hold"}, held_rec, s3_out); // Frozen under stall
            end
            holding  = model_valid && s3_busy && !flush;
            held_rec = s3_out;
            if (model_valid && !s3_busy) begin                 // Out-transfer
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("Error in %s: a record left the stage with none expected",
                             test_name);
                end else begin
                    check_value(test_name, expect_q.pop_front(), s3_out);
                    compared++;
                end
            end else if (model_valid && flush && (expect_q.size() != 0)) begin
                void'(expect_q.pop_front());                   // Flushed record never leaves
            end
            if (accept && !flush) begin
                expect_q.push_back(expected_record(s2_in, fwd_s3, fwd_s4));
            end
            if (flush) begin
                model_valid = 1'b0;
            end else if (!(model_valid && s3_busy)) begin
                model_valid = accept;
            end
            update_shadow(accept, s2_in.size, cf_req && cf_ack, cf_target, gpr_wr);
        end
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    function automatic dis_pkg::s2_instr_t random_instr();
        dis_pkg::s2_instr_t ins;
        ins.rd      = 5'($urandom_range(31));
        ins.rs1     = 5'($urandom_range(31));
        ins.rs2     = 5'($urandom_range(31));
        ins.imm     = $urandom;
        ins.uop     = 5'($urandom_range(31));
        ins.fu      = dis_pkg::fu_t'(1 << $urandom_range(4)); // One-hot unit
        ins.trap    = ($urandom_range(7) == 0);
        ins.opr_src = 8'($urandom_range(255));
        ins.size    = ($urandom_range(1) == 1) ? 2'b10 : 2'b01;
        ins.instr   = $urandom;
        return ins;
    endfunction

    function automatic dis_pkg::reg_addr_t pick_rd(input dis_pkg::s2_instr_t ins);
        case ($urandom_range(2))                               // Bias toward real matches
            0:       return ins.rs1;
            1:       return ins.rs2;
            default: return 5'($urandom_range(31));
        endcase
    endfunction

    task automatic issue(input dis_pkg::s2_instr_t ins);
        s2_valid = 1'b1;
        s2_in    = ins;
        do begin
            @(posedge g_clk);
        end while (!(s2_valid && !s2_busy));                   // Until transferred
    endtask

    task automatic idle(input int unsigned cycles);
        @(negedge g_clk);
        s2_valid   = 1'b0;
        gpr_wr.wen = 1'b0;
        cf_req     = 1'b0;
        cf_ack     = 1'b0;
        flush      = 1'b0;
        repeat (cycles) @(negedge g_clk);
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    initial begin
        dis_pkg::s2_instr_t ins;
        void'($urandom(62));
        g_resetn  = 1'b0;
        s2_valid  = 1'b0;
        s2_in     = '0;
        flush     = 1'b0;
        cf_req    = 1'b0;
        cf_ack    = 1'b0;
        cf_target = '0;
        fwd_s3    = '0;
        fwd_s4    = '0;
        gpr_wr    = '0;
        s3_busy   = 1'b0;
        bp_random = 1'b0;
        errors    = 0;
        compared  = 0;
        test_name = "reset";
        repeat (8) @(negedge g_clk);
        g_resetn = 1'b1;

        test_name = "random";                                  // Writes, forwards and redirects
        bp_random = 1'b1;
        repeat (60) begin
            ins = random_instr();
            @(negedge g_clk);
            gpr_wr    = '{wen: 1'($urandom_range(1)), rd: 5'($urandom_range(31)),
                          wdata: $urandom};
            fwd_s3    = '{rd: pick_rd(ins), wdata: $urandom, load: 1'b0, csr: 1'b0};
            fwd_s4    = '{rd: pick_rd(ins), wdata: $urandom, load: 1'b0, csr: 1'b0};
            cf_req    = ($urandom_range(7) == 0);
            cf_ack    = cf_req && ($urandom_range(1) == 1);
            cf_target = $urandom & 32'hffff_fffe;              // Half-word aligned
            issue(ins);
        end
        @(negedge g_clk);
        bp_random = 1'b0;
        s3_busy   = 1'b0;
        idle(4);

        test_name = "forward";
        gpr_wr = '{wen: 1'b1, rd: 5'd5, wdata: 32'h1111_0005};
        @(negedge g_clk);
        gpr_wr = '{wen: 1'b1, rd: 5'd6, wdata: 32'h2222_0006};
        @(negedge g_clk);
        gpr_wr.wen  = 1'b0;
        ins         = random_instr();
        ins.rs1     = 5'd5;
        ins.rs2     = 5'd6;
        ins.opr_src = SRC_REGS;
        fwd_s3      = '{rd: 5'd5, wdata: 32'h3333_0003, load: 1'b0, csr: 1'b0};
        fwd_s4      = '{rd: 5'd5, wdata: 32'h4444_0004, load: 1'b0, csr: 1'b0};
        issue(ins);                                            // Stage 3 beats stage 4
        @(negedge g_clk);
        fwd_s3.rd = 5'd7;
        issue(ins);                                            // Stage 4 beats the file
        @(negedge g_clk);
        fwd_s4.rd = 5'd8;
        issue(ins);
        @(negedge g_clk);
        ins.rs1   = 5'd0;
        fwd_s3.rd = 5'd0;
        issue(ins);                                            // x0 ignores forwarding
        idle(2);

        test_name = "hazard";
        for (int k = 0; k < 3; k++) begin
            ins         = random_instr();
            ins.rs1     = 5'd9;
            ins.rs2     = 5'd10;
            ins.opr_src = SRC_REGS;
            fwd_s3 = '{rd: (k < 2) ? 5'd9 : 5'd0, wdata: 32'h5a5a_0009, load: k == 0,
                       csr: k == 1};
            fwd_s4 = '{rd: 5'd10, wdata: 32'ha5a5_000a, load: 1'b0, csr: k == 2};
            s2_valid = 1'b1;
            s2_in    = ins;
            repeat (3) @(negedge g_clk);                       // Held off while pending
            fwd_s3.load = 1'b0;
            fwd_s3.csr  = 1'b0;
            fwd_s4.csr  = 1'b0;
            issue(ins);
            @(negedge g_clk);
        end
        fwd_s3 = '0;
        fwd_s4 = '0;
        idle(2);

        test_name = "pc";
        repeat (3) begin
            @(negedge g_clk);
            issue(random_instr());
        end
        @(negedge g_clk);
        s2_valid  = 1'b0;
        cf_req    = 1'b1;                                      // Request alone has no effect
        cf_target = 32'h0000_4000;
        @(negedge g_clk);
        cf_req = 1'b0;
        issue(random_instr());                                 // Still on the sequential PC
        @(negedge g_clk);
        s2_valid = 1'b0;
        cf_req   = 1'b1;
        cf_ack   = 1'b1;
        @(negedge g_clk);
        cf_req = 1'b0;
        cf_ack = 1'b0;
        repeat (3) begin
            issue(random_instr());
            @(negedge g_clk);
        end
        idle(2);

        test_name = "rd_zero";
        for (int k = 0; k < 3; k++) begin
            ins      = random_instr();
            ins.rd   = 5'd12;
            ins.fu   = dis_pkg::fu_t'(1 << ((k == 1) ? dis_pkg::FU_CFU : dis_pkg::FU_LSU));
            ins.uop  = (k == 1) ? 5'b00101 : 5'b10000;         // Branch or store
            ins.trap = (k == 2);
            @(negedge g_clk);
            issue(ins);
        end
        idle(2);

        test_name = "backpressure";
        s3_busy = 1'b1;
        issue(random_instr());                                 // Parks in the register
        @(negedge g_clk);
        ins      = random_instr();
        s2_valid = 1'b1;
        s2_in    = ins;
        repeat (4) @(negedge g_clk);                           // Stalled behind it
        s2_valid = 1'b0;
        flush    = 1'b1;
        @(negedge g_clk);
        flush   = 1'b0;
        s3_busy = 1'b0;
        issue(ins);
        @(negedge g_clk);
        s2_valid = 1'b0;
        s3_busy  = 1'b1;
        repeat (3) @(negedge g_clk);                           // Held record stays frozen
        s3_busy = 1'b0;
        issue(random_instr());
        idle(4);

        for (int n = 0; (n < 50) && (expect_q.size() != 0); n++) begin
            @(negedge g_clk);
        end
        if (expect_q.size() != 0) begin
            errors++;
            $display("Error: %0d expected records never left the stage", expect_q.size());
        end
        $display("Run complete: %0d records compared, %0d errors", compared, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: dis_stage.f
+incdir+bench
rtl/dis_pkg.sv
rtl/dis_gprs.sv
rtl/dis_operand_fwd.sv
rtl/dis_pc_track.sv
rtl/dis_operand_mux.sv
rtl/dis_pipe_reg.sv
rtl/dis_stage.sv
bench/tb_dis_stage.sv

// File: Makefile
# Verilator build and run for the dispatch stage testbench.
# Override any variable on the command line, e.g. make OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_dis_stage
RTL_TOP   ?= dis_stage
FILELIST  ?= dis_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
